//--- hw/pci_pkg.sv
`default_nettype none

package pci_pkg;

    // Memory and bus sizes
    localparam int ADDR_W = 8;  // 256 words
    localparam int DATA_W = 32;
    localparam int OPC_W  = 4;

    // Core held in reset this long after start
    localparam int RESET_CLK_CYCLES = 4;
    localparam int RST_CNT_W        = $clog2(RESET_CLK_CYCLES + 1);

    // Request buffer
    localparam int BUF_DEPTH = 2;
    localparam int BUF_PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

    // Opcode sits in the top OPC_W bits of the instruction word
    typedef enum logic [OPC_W-1:0] {
        OP_HALT = 4'h0,
        OP_LDI  = 4'h1,
        OP_LD   = 4'h2,
        OP_ADD  = 4'h3,
        OP_SUB  = 4'h4,
        OP_ST   = 4'h5,
        OP_JNZ  = 4'h6
    } pci_opcode_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_MEM,
        S_WAIT,   // Bus turnaround, load writeback
        S_HALT
    } pci_core_state_e;

    typedef enum logic [1:0] {
        C_LOAD,
        C_RELEASE,
        C_RUN,
        C_DONE
    } pci_ctrl_state_e;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;    // 1 = write
        logic [ADDR_W-1:0] addr;  // Word address
        logic [DATA_W-1:0] wdata;
    } pci_bus_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] rdata;
    } pci_bus_rsp_t;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } pci_host_req_t;

endpackage

`default_nettype wire

//--- hw/pci_controller.sv
`timescale 1ns/10ps
`default_nettype none

module pci_controller (
    input  wire logic                       sys_clk_i,
    input  wire logic                       rst_n_i,
    input  wire logic                       start_i,      // One-cycle pulse
    input  wire logic                       host_we_i,
    input  wire logic [pci_pkg::ADDR_W-1:0] host_addr_i,
    input  wire logic [pci_pkg::DATA_W-1:0] host_wdata_i,
    input  wire logic                       halted_i,
    output logic                            core_rst_n_o,
    output pci_pkg::pci_host_req_t          host_req_o,
    output logic                            done_o
);

    pci_pkg::pci_ctrl_state_e state_q;

    logic [pci_pkg::RST_CNT_W-1:0] cnt_q;  // Release delay
    logic                          core_rst_n_q;
    logic                          host_wr_ok;

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= pci_pkg::C_LOAD;
            cnt_q        <= '0;
            core_rst_n_q <= 1'b0;
        end else begin
            case (state_q)
                pci_pkg::C_LOAD, pci_pkg::C_DONE: begin
                    if (start_i) begin
                        state_q      <= pci_pkg::C_RELEASE;
                        cnt_q        <= '0;
                        core_rst_n_q <= 1'b0;  // Clears a halted core before rerun
                    end
                end

                pci_pkg::C_RELEASE: begin
                    if (int'(cnt_q) == pci_pkg::RESET_CLK_CYCLES - 1) begin
                        state_q      <= pci_pkg::C_RUN;
                        core_rst_n_q <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                pci_pkg::C_RUN: begin
                    if (halted_i) begin
                        state_q <= pci_pkg::C_DONE;
                    end
                end

                default: begin
                    state_q <= pci_pkg::C_LOAD;
                end
            endcase
        end
    end

    // Writes only while the core is in reset or stopped
    assign host_wr_ok = (state_q == pci_pkg::C_LOAD) || (state_q == pci_pkg::C_DONE);

    always_comb begin
        host_req_o.we    = host_we_i && host_wr_ok;
        host_req_o.addr  = host_addr_i;
        host_req_o.wdata = host_wdata_i;
    end

    assign core_rst_n_o = core_rst_n_q;
    assign done_o       = (state_q == pci_pkg::C_DONE);

endmodule

`default_nettype wire

//--- hw/pci_core.sv
`timescale 1ns/10ps
`default_nettype none

module pci_core (
    input  wire logic                 sys_clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 core_rst_n_i,  // From controller, sampled at the clock
    output pci_pkg::pci_bus_req_t     bus_req_o,
    input  wire pci_pkg::pci_bus_rsp_t bus_rsp_i,
    output logic                      halted_o
);

    pci_pkg::pci_core_state_e state_q;
    pci_pkg::pci_opcode_e     opcode;

    logic [pci_pkg::ADDR_W-1:0] pc_q;
    logic [pci_pkg::DATA_W-1:0] ir_q;
    logic [pci_pkg::DATA_W-1:0] acc_q;
    logic [pci_pkg::DATA_W-1:0] mdr_q;   // Memory operand
    logic [pci_pkg::ADDR_W-1:0] operand;
    logic                       bus_act;

    assign opcode  = pci_pkg::pci_opcode_e'(ir_q[pci_pkg::DATA_W-1 -: pci_pkg::OPC_W]);
    assign operand = ir_q[pci_pkg::ADDR_W-1:0];
    assign bus_act = (state_q == pci_pkg::S_FETCH) || (state_q == pci_pkg::S_MEM);

    // Request held steady from state and registers until ack
    always_comb begin
        bus_req_o.cyc   = bus_act;
        bus_req_o.stb   = bus_act;
        bus_req_o.we    = (state_q == pci_pkg::S_MEM) && (opcode == pci_pkg::OP_ST);
        bus_req_o.addr  = (state_q == pci_pkg::S_MEM) ? operand : pc_q;
        bus_req_o.wdata = acc_q;
    end

    assign halted_o = (state_q == pci_pkg::S_HALT);

    always_ff @(posedge sys_clk_i) begin
        if ((state_q == pci_pkg::S_MEM) && bus_rsp_i.ack) begin
            mdr_q <= bus_rsp_i.rdata;
        end
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= pci_pkg::S_WAIT;  // Idle bus, ir holds HALT so no writeback
            pc_q    <= '0;
            ir_q    <= '0;
            acc_q   <= '0;
        end else if (!core_rst_n_i) begin
            state_q <= pci_pkg::S_WAIT;
            pc_q    <= '0;
            ir_q    <= '0;
            acc_q   <= '0;
        end else begin
            case (state_q)
                pci_pkg::S_FETCH: begin
                    if (bus_rsp_i.ack) begin
                        ir_q    <= bus_rsp_i.rdata;
                        pc_q    <= pc_q + 1'b1;
                        state_q <= pci_pkg::S_DECODE;
                    end
                end

                pci_pkg::S_DECODE: begin
                    case (opcode)
                        pci_pkg::OP_LDI: begin
                            acc_q   <= {{(pci_pkg::DATA_W-pci_pkg::ADDR_W){1'b0}}, operand};
                            state_q <= pci_pkg::S_FETCH;
                        end
                        pci_pkg::OP_JNZ: begin
                            if (acc_q != '0) begin
                                pc_q <= operand;  // Taken branch
                            end
                            state_q <= pci_pkg::S_FETCH;
                        end
                        pci_pkg::OP_LD,
                        pci_pkg::OP_ADD,
                        pci_pkg::OP_SUB,
                        pci_pkg::OP_ST: begin
                            state_q <= pci_pkg::S_MEM;
                        end
                        default: begin
                            state_q <= pci_pkg::S_HALT;  // HALT and undefined codes
                        end
                    endcase
                end

                pci_pkg::S_MEM: begin
                    if (bus_rsp_i.ack) begin
                        state_q <= pci_pkg::S_WAIT;
                    end
                end

                pci_pkg::S_WAIT: begin
                    // Apply loaded operand, stores have nothing to write back
                    case (opcode)
                        pci_pkg::OP_LD:  acc_q <= mdr_q;
                        pci_pkg::OP_ADD: acc_q <= acc_q + mdr_q;
                        pci_pkg::OP_SUB: acc_q <= acc_q - mdr_q;
                        default:         acc_q <= acc_q;
                    endcase
                    state_q <= pci_pkg::S_FETCH;
                end

                pci_pkg::S_HALT: begin
                    state_q <= pci_pkg::S_HALT;  // Only a core reset leaves
                end

                default: begin
                    state_q <= pci_pkg::S_HALT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/pci_bus_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module pci_bus_buffer (
    input  wire logic                  sys_clk_i,
    input  wire logic                  rst_n_i,
    input  wire pci_pkg::pci_bus_req_t up_req_i,   // From core
    output pci_pkg::pci_bus_rsp_t      up_rsp_o,
    output pci_pkg::pci_bus_req_t      dn_req_o,   // To memory
    input  wire pci_pkg::pci_bus_rsp_t dn_rsp_i
);

    pci_pkg::pci_bus_req_t fifo_q [pci_pkg::BUF_DEPTH];

    logic [pci_pkg::BUF_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [pci_pkg::BUF_CNT_W-1:0] count_q;
    logic [pci_pkg::DATA_W-1:0]    up_rdata_q;
    logic                          rd_pend_q;  // A read sits in the queue
    logic                          up_ack_q;
    logic                          full, push, pop, pop_rd;

    assign full = (int'(count_q) == pci_pkg::BUF_DEPTH);

    // No re-accept of a request whose ack is going out, nothing passes a read
    assign push   = up_req_i.cyc && up_req_i.stb && !up_ack_q && !rd_pend_q && !full;
    assign pop    = dn_rsp_i.ack && (count_q != '0);
    assign pop_rd = pop && !fifo_q[rd_ptr_q].we;

    always_ff @(posedge sys_clk_i) begin
        if (push) begin
            fifo_q[wr_ptr_q] <= up_req_i;
        end
        if (pop_rd) begin
            up_rdata_q <= dn_rsp_i.rdata;
        end
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            rd_pend_q <= 1'b0;
            up_ack_q  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= (int'(wr_ptr_q) == pci_pkg::BUF_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (int'(rd_ptr_q) == pci_pkg::BUF_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase

            if (push && !up_req_i.we) begin
                rd_pend_q <= 1'b1;
            end else if (pop_rd) begin
                rd_pend_q <= 1'b0;
            end

            up_ack_q <= (push && up_req_i.we) || pop_rd;  // Posted write or returned read
        end
    end

    // Head entry goes downstream
    always_comb begin
        dn_req_o     = fifo_q[rd_ptr_q];
        dn_req_o.cyc = (count_q != '0);
        dn_req_o.stb = (count_q != '0);
    end

    assign up_rsp_o.ack   = up_ack_q;
    assign up_rsp_o.rdata = up_rdata_q;

endmodule

`default_nettype wire

//--- hw/pci_memory.sv
`timescale 1ns/10ps
`default_nettype none

module pci_memory (
    input  wire logic                   sys_clk_i,
    input  wire logic                   rst_n_i,
    input  wire pci_pkg::pci_bus_req_t  bus_req_i,
    output pci_pkg::pci_bus_rsp_t       bus_rsp_o,
    input  wire pci_pkg::pci_host_req_t host_req_i,
    output logic [pci_pkg::DATA_W-1:0]  host_rdata_o
);

    logic [pci_pkg::DATA_W-1:0] mem_q [2**pci_pkg::ADDR_W];

    logic [pci_pkg::DATA_W-1:0] bus_rdata_q;
    logic [pci_pkg::DATA_W-1:0] host_rdata_q;
    logic                       ack_q;
    logic                       bus_take;

    // New request only, the acked one is still on the bus for a cycle
    assign bus_take = bus_req_i.cyc && bus_req_i.stb && !ack_q;

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_take;  // Always one cycle after stb
        end
    end

    // Host and bus never write the same word in one cycle
    always_ff @(posedge sys_clk_i) begin
        if (bus_take && bus_req_i.we) begin
            mem_q[bus_req_i.addr] <= bus_req_i.wdata;
        end
        if (host_req_i.we) begin
            mem_q[host_req_i.addr] <= host_req_i.wdata;
        end
        if (bus_take) begin
            bus_rdata_q <= mem_q[bus_req_i.addr];
        end
        host_rdata_q <= mem_q[host_req_i.addr];  // Old data on a same-cycle write
    end

    assign bus_rsp_o.ack   = ack_q;
    assign bus_rsp_o.rdata = bus_rdata_q;
    assign host_rdata_o    = host_rdata_q;

endmodule

`default_nettype wire

//--- hw/pci_top.sv
`timescale 1ns/10ps
`default_nettype none

module pci_top (
    input  wire logic                       sys_clk_i,
    input  wire logic                       rst_n_i,
    input  wire logic                       start_i,
    input  wire logic                       host_we_i,
    input  wire logic [pci_pkg::ADDR_W-1:0] host_addr_i,
    input  wire logic [pci_pkg::DATA_W-1:0] host_wdata_i,
    output logic [pci_pkg::DATA_W-1:0]      host_rdata_o,
    output logic                            done_o
);

    pci_pkg::pci_bus_req_t  core_req, mem_req;
    pci_pkg::pci_bus_rsp_t  core_rsp, mem_rsp;
    pci_pkg::pci_host_req_t host_req;
    logic                   core_rst_n;
    logic                   core_halted;

    pci_controller u_controller (
        .sys_clk_i    (sys_clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (start_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .halted_i     (core_halted),
        .core_rst_n_o (core_rst_n),
        .host_req_o   (host_req),
        .done_o       (done_o)
    );

    pci_core u_core (
        .sys_clk_i    (sys_clk_i),
        .rst_n_i      (rst_n_i),
        .core_rst_n_i (core_rst_n),
        .bus_req_o    (core_req),
        .bus_rsp_i    (core_rsp),
        .halted_o     (core_halted)
    );

    // Posts stores, keeps loads behind them
    pci_bus_buffer u_bus_buffer (
        .sys_clk_i (sys_clk_i),
        .rst_n_i   (rst_n_i),
        .up_req_i  (core_req),
        .up_rsp_o  (core_rsp),
        .dn_req_o  (mem_req),
        .dn_rsp_i  (mem_rsp)
    );

    pci_memory u_memory (
        .sys_clk_i    (sys_clk_i),
        .rst_n_i      (rst_n_i),
        .bus_req_i    (mem_req),
        .bus_rsp_o    (mem_rsp),
        .host_req_i   (host_req),
        .host_rdata_o (host_rdata_o)
    );

endmodule

`default_nettype wire

//--- dv/pci_checker.sv
`timescale 1ns/10ps
`default_nettype none

module pci_checker (
    input  wire logic                       sys_clk_i,
    input  wire logic                       chk_vld_i,    // Host read issued this cycle
    input  wire logic [pci_pkg::ADDR_W-1:0] chk_addr_i,
    input  wire logic [pci_pkg::DATA_W-1:0] chk_exp_i,
    input  wire logic [pci_pkg::DATA_W-1:0] rdata_i,      // DUT host read data
    input  wire logic                       done_i,
    input  wire logic                       idle_i,       // Core held in reset by the test
    input  wire logic                       test_done_i,
    input  wire logic [3:0]                 test_id_i,
    output int                              n_tests_o,
    output int                              n_bad_tests_o,
    output int                              n_words_o,
    output int                              n_errs_o
);

    logic                       pend_q;
    logic [pci_pkg::ADDR_W-1:0] addr_q;
    logic [pci_pkg::DATA_W-1:0] exp_q;
    int                         test_errs;
    int                         test_words;

    initial begin
        pend_q        = 1'b0;
        n_tests_o     = 0;
        n_bad_tests_o = 0;
        n_words_o     = 0;
        n_errs_o      = 0;
        test_errs     = 0;
        test_words    = 0;
    end

    // Host read data shows up one cycle after the address
    always @(posedge sys_clk_i) begin
        pend_q <= chk_vld_i;
        addr_q <= chk_addr_i;
        exp_q  <= chk_exp_i;
    end

    // Compare mid-cycle, well away from the edges
    always @(negedge sys_clk_i) begin
        if (pend_q) begin
            n_words_o++;
            test_words++;
            if (rdata_i !== exp_q) begin
                $display("Fail t=%0t addr=%02h exp=%08h got=%08h",
                         $time, addr_q, exp_q, rdata_i);
                n_errs_o++;
                test_errs++;
            end
        end
        if (idle_i && done_i) begin
            $display("done_o went high at t=%0t while the core was held in reset", $time);
            n_errs_o++;
            test_errs++;
        end
        if (test_done_i) begin
            n_tests_o++;
            if (test_errs != 0) begin
                n_bad_tests_o++;
            end
            $display("test %0d %s: %0d words, %0d errors", test_id_i,
                     (test_errs == 0) ? "ok" : "bad", test_words, test_errs);
            test_errs  = 0;
            test_words = 0;
        end
    end

endmodule

`default_nettype wire

//--- dv/pci_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module pci_asserts (
    input  wire logic                  sys_clk_i,
    input  wire logic                  rst_n_i,
    input  wire pci_pkg::pci_bus_req_t up_req_i,
    input  wire pci_pkg::pci_bus_rsp_t up_rsp_i,
    input  wire pci_pkg::pci_bus_req_t dn_req_i,
    input  wire pci_pkg::pci_bus_rsp_t dn_rsp_i,
    input  wire logic                  full_i
);

    int err_cnt = 0;  // Read by the testbench at the end

    up_stb_cyc: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        up_req_i.stb |-> up_req_i.cyc)
        else begin
            $error("upstream stb without cyc");
            err_cnt++;
        end

    dn_stb_cyc: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        dn_req_i.stb |-> dn_req_i.cyc)
        else begin
            $error("downstream stb without cyc");
            err_cnt++;
        end

    // Requester holds its fields until ack
    up_req_hold: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        (up_req_i.stb && !up_rsp_i.ack) |=> $stable(up_req_i))
        else begin
            $error("upstream request changed before ack");
            err_cnt++;
        end

    full_no_wr_ack: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        (full_i && up_req_i.stb && up_req_i.we) |=> !up_rsp_i.ack)
        else begin
            $error("write acked while the queue was full");
            err_cnt++;
        end

    dn_ack_next: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        (dn_req_i.stb && !dn_rsp_i.ack) |=> dn_rsp_i.ack)
        else begin
            $error("memory ack missing one cycle after stb");
            err_cnt++;
        end

endmodule

bind pci_bus_buffer pci_asserts u_asserts (
    .sys_clk_i (sys_clk_i),
    .rst_n_i   (rst_n_i),
    .up_req_i  (up_req_i),
    .up_rsp_i  (up_rsp_o),
    .dn_req_i  (dn_req_o),
    .dn_rsp_i  (dn_rsp_i),
    .full_i    (full)
);

`default_nettype wire

//--- dv/pci_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pci_tb;

    localparam int          MEM_WORDS      = 2**pci_pkg::ADDR_W;
    localparam int          DRIVE_DLY      = 5;
    localparam int          DONE_TIMEOUT   = 5000;  // Cycles per program run
    localparam int          REF_STEP_LIMIT = 4096;
    localparam int          NUM_TESTS      = 5;
    localparam logic [31:0] LFSR_SEED      = 32'hbf2ccf29;

    logic                       sys_clk;
    logic                       rst_n;
    logic                       start;
    logic                       host_we;
    logic [pci_pkg::ADDR_W-1:0] host_addr;
    logic [pci_pkg::DATA_W-1:0] host_wdata;
    logic [pci_pkg::DATA_W-1:0] host_rdata;
    logic                       done;
    logic                       chk_vld;
    logic [pci_pkg::DATA_W-1:0] chk_exp;
    logic                       test_done;
    logic                       idle;
    logic [3:0]                 test_id;
    logic [31:0]                lfsr_q;
    logic [pci_pkg::DATA_W-1:0] img_mem [MEM_WORDS];  // Loaded into the DUT
    logic [pci_pkg::DATA_W-1:0] exp_mem [MEM_WORDS];  // Expected after the run
    int                         prog_pc;
    int                         n_tests, n_bad_tests, n_words, n_errs;

    pci_top dut_i (
        .sys_clk_i    (sys_clk),
        .rst_n_i      (rst_n),
        .start_i      (start),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_rdata_o (host_rdata),
        .done_o       (done)
    );

    pci_checker u_checker (
        .sys_clk_i     (sys_clk),
        .chk_vld_i     (chk_vld),
        .chk_addr_i    (host_addr),
        .chk_exp_i     (chk_exp),
        .rdata_i       (host_rdata),
        .done_i        (done),
        .idle_i        (idle),
        .test_done_i   (test_done),
        .test_id_i     (test_id),
        .n_tests_o     (n_tests),
        .n_bad_tests_o (n_bad_tests),
        .n_words_o     (n_words),
        .n_errs_o      (n_errs)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr32(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr32(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Middle bits are don't care, so fill them with noise
    function automatic void emit(input logic [3:0] op, input logic [7:0] opd);
        img_mem[prog_pc] = {op, 20'(rand_bits(20)), opd};
        prog_pc++;
    endfunction

    function automatic void fill_image(input logic [7:0] tag);
        logic [7:0] b;
        for (int a = 0; a < MEM_WORDS; a++) begin
            b          = 8'(a);
            img_mem[a] = {~b, b, tag, b ^ 8'h3c};
        end
        prog_pc = 0;
    endfunction

    // ISA model over the whole memory image
    function automatic void ref_run();
        logic [7:0]  pc;
        logic [7:0]  opd;
        logic [31:0] acc;
        logic [31:0] ir;
        bit          running;
        int          steps;
        for (int a = 0; a < MEM_WORDS; a++) begin
            exp_mem[a] = img_mem[a];
        end
        pc      = '0;
        acc     = '0;
        running = 1'b1;
        steps   = 0;
        while (running && steps < REF_STEP_LIMIT) begin
            ir  = exp_mem[pc];
            opd = ir[7:0];
            pc  = pc + 8'd1;
            steps++;
            case (ir[31:28])
                pci_pkg::OP_LDI: acc = {24'h0, opd};
                pci_pkg::OP_LD:  acc = exp_mem[opd];
                pci_pkg::OP_ADD: acc = acc + exp_mem[opd];
                pci_pkg::OP_SUB: acc = acc - exp_mem[opd];
                pci_pkg::OP_ST:  exp_mem[opd] = acc;
                pci_pkg::OP_JNZ: begin
                    if (acc != '0) begin
                        pc = opd;
                    end
                end
                default:         running = 1'b0;  // HALT and undefined codes
            endcase
        end
    endfunction

    task automatic step_cycle();
        @(posedge sys_clk);
        #(DRIVE_DLY);
    endtask

    task automatic load_image();
        for (int a = 0; a < MEM_WORDS; a++) begin
            host_we    = 1'b1;
            host_addr  = 8'(a);
            host_wdata = img_mem[a];
            step_cycle();
        end
        host_we = 1'b0;
    endtask

    task automatic dump_check();
        for (int a = 0; a < MEM_WORDS; a++) begin
            host_addr = 8'(a);
            chk_vld   = 1'b1;
            chk_exp   = exp_mem[a];
            step_cycle();
        end
        chk_vld = 1'b0;
    endtask

    task automatic end_test();
        test_done = 1'b1;
        step_cycle();
        test_done = 1'b0;
        test_id   = test_id + 4'd1;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        if (!done) begin
            $display("timeout waiting for done");
            $display("sim failed");
            $finish;
        end
    endtask

    task automatic run_and_dump();
        load_image();
        ref_run();
        start = 1'b1;
        step_cycle();
        start = 1'b0;
        wait_done();
        dump_check();
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        chk_vld    = 1'b0;
        chk_exp    = '0;
        test_done  = 1'b0;
        idle       = 1'b1;
        test_id    = 4'd1;
        lfsr_q     = LFSR_SEED;
        repeat (3) @(posedge sys_clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;

        // Load and read back with the core still in reset
        for (int a = 0; a < MEM_WORDS; a++) begin
            img_mem[a] = rand_bits(32);
            exp_mem[a] = img_mem[a];
        end
        load_image();
        dump_check();
        end_test();
        idle = 1'b0;

        // Arithmetic, 0x83 + 0x84 always wraps
        fill_image(8'h02);
        img_mem[8'h80] = rand_bits(32);
        img_mem[8'h81] = rand_bits(32);
        img_mem[8'h82] = rand_bits(32);
        img_mem[8'h83] = rand_bits(32) | 32'h8000_0000;
        img_mem[8'h84] = rand_bits(32) | 32'h8000_0000;
        emit(pci_pkg::OP_LDI, 8'(rand_bits(8)));
        emit(pci_pkg::OP_ST, 8'hc0);
        emit(pci_pkg::OP_LD, 8'h80);
        emit(pci_pkg::OP_ADD, 8'h81);
        emit(pci_pkg::OP_ST, 8'hc1);
        emit(pci_pkg::OP_SUB, 8'h82);
        emit(pci_pkg::OP_ST, 8'hc2);
        emit(pci_pkg::OP_LD, 8'h83);
        emit(pci_pkg::OP_ADD, 8'h84);
        emit(pci_pkg::OP_ST, 8'hc3);
        emit(pci_pkg::OP_HALT, 8'h00);
        run_and_dump();
        end_test();

        // Countdown loop, running sum with back-to-back stores
        fill_image(8'h03);
        img_mem[8'h81] = 32'd1;
        img_mem[8'h82] = rand_bits(32);
        emit(pci_pkg::OP_LDI, 8'd3 + 8'(rand_bits(3)));
        emit(pci_pkg::OP_ST, 8'h80);
        emit(pci_pkg::OP_LD, 8'h82);  // Loop head at 2
        emit(pci_pkg::OP_ADD, 8'h80);
        emit(pci_pkg::OP_ST, 8'h82);
        emit(pci_pkg::OP_ST, 8'h83);
        emit(pci_pkg::OP_ST, 8'h84);
        emit(pci_pkg::OP_LD, 8'h80);
        emit(pci_pkg::OP_SUB, 8'h81);
        emit(pci_pkg::OP_ST, 8'h80);
        emit(pci_pkg::OP_JNZ, 8'h02);
        emit(pci_pkg::OP_HALT, 8'h00);
        run_and_dump();
        end_test();

        // Load right behind a store to the same word
        fill_image(8'h04);
        img_mem[8'h90] = rand_bits(32);
        emit(pci_pkg::OP_LDI, 8'(rand_bits(8)));
        emit(pci_pkg::OP_ADD, 8'h90);
        emit(pci_pkg::OP_ST, 8'ha0);
        emit(pci_pkg::OP_LD, 8'ha0);
        emit(pci_pkg::OP_ADD, 8'ha0);
        emit(pci_pkg::OP_ST, 8'ha1);
        emit(pci_pkg::OP_HALT, 8'h00);
        run_and_dump();
        end_test();

        // Undefined opcode stops the core, then a rerun from C_DONE
        fill_image(8'h05);
        emit(pci_pkg::OP_LDI, 8'(rand_bits(8)));
        emit(pci_pkg::OP_ST, 8'hb0);
        emit({1'b1, 3'(rand_bits(3))}, 8'hb1);
        emit(pci_pkg::OP_ST, 8'hb1);
        emit(pci_pkg::OP_HALT, 8'h00);
        run_and_dump();
        fill_image(8'h06);
        img_mem[8'hb2] = rand_bits(32);
        img_mem[8'hb4] = rand_bits(32);
        emit(pci_pkg::OP_LDI, 8'(rand_bits(8)));
        emit(pci_pkg::OP_ADD, 8'hb2);
        emit(pci_pkg::OP_ST, 8'hb3);
        emit(pci_pkg::OP_LD, 8'hb3);
        emit(pci_pkg::OP_SUB, 8'hb4);
        emit(pci_pkg::OP_ST, 8'hb5);
        emit(pci_pkg::OP_HALT, 8'h00);
        run_and_dump();
        end_test();

        step_cycle();
        $display("%0d tests, %0d failed, %0d words checked, %0d errors, %0d assertion errors",
                 n_tests, n_bad_tests, n_words, n_errs, dut_i.u_bus_buffer.u_asserts.err_cnt);
        if (n_tests == NUM_TESTS && n_bad_tests == 0 && n_errs == 0 &&
            dut_i.u_bus_buffer.u_asserts.err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/pci_pkg.sv
hw/pci_controller.sv
hw/pci_core.sv
hw/pci_bus_buffer.sv
hw/pci_memory.sv
hw/pci_top.sv
dv/pci_checker.sv
dv/pci_asserts.sv
dv/pci_tb.sv

//--- Bender.yml
package:
  name: pci_harness

sources:
  - files:
      - hw/pci_pkg.sv
      - hw/pci_controller.sv
      - hw/pci_core.sv
      - hw/pci_bus_buffer.sv
      - hw/pci_memory.sv
      - hw/pci_top.sv
  - target: test
    files:
      - dv/pci_checker.sv
      - dv/pci_asserts.sv
      - dv/pci_tb.sv
